// ==== sens_gamma.f ====
+incdir+verilog
verilog/gamma_pkg.sv
verilog/gamma_regs.sv
verilog/gamma_frame_ctrl.sv
verilog/gamma_color_track.sv
verilog/gamma_table.sv
verilog/gamma_interp.sv
verilog/sens_gamma.sv
verification/sens_gamma_chk.sv
verification/sens_gamma_tb.sv

// ==== verification/sens_gamma_cases.txt ====
# ctrl(hex: bayer[1:0] en[2] repet[3] soft trig[4]) trig_in h0 h1 h2
# frames lines pixels_per_line expected_sof_count, text after the ninth column is ignored
00 1 0 0 0 1 2 6 0    en low, trig_in pending
04 0 0 0 0 1 2 6 0    enabled, no trigger
04 1 0 0 0 2 2 6 1    trig_in, second frame blocked
14 0 0 0 0 2 2 6 1    soft trigger
0c 0 0 0 0 3 2 6 3    repeat mode
08 0 0 0 0 1 2 6 0    repeat with en low
0c 0 0 0 0 1 4 9 1    bayer 0
0d 0 0 0 0 1 4 9 1    bayer 1
0e 0 0 0 0 1 4 9 1    bayer 2
0f 0 0 0 0 1 4 9 1    bayer 3
0c 0 1 2 0 1 8 5 1    subchannels 2+3+rest
0c 0 0 0 3 1 7 4 1    subchannels 1+1+rest
0d 0 2 1 1 1 6 64 1   long lines, all diff codes

// ==== verification/sens_gamma_tb.sv ====
// testbench for the sensor gamma converter, file-driven cases checked against a reference model
`include "gamma_config.svh"

module sens_gamma_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_cases = 32;
    localparam int hist_len  = 8;   // ring deeper than the latency

    logic        pclk = 1'b0;
    logic        mrst = 1'b1;
    logic        cmd_we = 1'b0;
    logic [1:0]  cmd_addr = '0;
    logic [31:0] cmd_data = '0;
    logic [15:0] pxd_in = '0;
    logic        hact_in = 1'b0;
    logic        sof_in = 1'b0;
    logic        eof_in = 1'b0;
    logic        trig_in = 1'b0;
    logic [7:0]  pxd_out;
    logic        hact_out;
    logic        sof_out;
    logic        eof_out;

    logic [15:0] lfsr = 16'd16;
    logic [17:0] model_mem [4096];     // mirror of every table write
    logic [7:0]  exp_pix = '0;         // expected output for the pixel being driven
    logic        hist_hact [hist_len];
    logic        hist_eof [hist_len];
    logic [7:0]  hist_pix [hist_len];
    int          c_ctrl [max_cases];
    int          c_trig [max_cases];
    int          c_h [max_cases][3];
    int          c_frames [max_cases];
    int          c_lines [max_cases];
    int          c_pix [max_cases];
    int          c_sof [max_cases];
    int          num_cases = 0;
    int          err_cnt = 0;
    int          fail_cases = 0;
    int          sof_cnt = 0;
    int          mon_cyc = 0;
    int          cyc_cnt = 0;
    int          limit = 200;
    bit          ok;

    always #2 pclk = ~pclk;

    sens_gamma u_dut (.*);

    bind sens_gamma sens_gamma_chk u_chk (
        .pclk(pclk), .mrst(mrst), .hact_in(hact_in), .hact_out(hact_out),
        .sof_out(sof_out), .eof_out(eof_out), .pxd_out(pxd_out), .subchn(subchn)
    );

    // x^16+x^14+x^13+x^11+1, one step per bit
    function automatic logic [15:0] take_bits(int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // slope times low byte, round at bit 7, keep 10 bits, drop 2 guard bits
    function automatic logic [7:0] interp_ref(logic [17:0] w, logic [7:0] lo);
        int         diff;
        int         p;
        logic [9:0] v;
        diff = int'(w[16:10]) - (w[16] ? 128 : 0);
        if (w[17]) diff = diff * 16;   // coarse code
        p = diff * int'(lo);
        v = 10'(int'(w[9:0]) + (p >>> 8) + ((p >>> 7) & 1));
        return v[9:2];
    endfunction

    // subchannel of a line: heights are lines minus one, last one holds
    function automatic int subchn_ref(int line, int h0, int h1, int h2);
        int s;
        int left;
        int h;
        s = 0;
        left = line;
        h = h0 + 1;
        while (left >= h && s < `GAMMA_NUM_CHN - 1) begin
            left -= h;
            s++;
            h = ((s == 1) ? h1 : h2) + 1;
        end
        return s;
    endfunction

    task automatic report_value(string name, logic [31:0] exp, logic [31:0] got);
        $display("ERR t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
        err_cnt++;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge pclk);
            cmd_we  <= 1'b0;
            hact_in <= 1'b0;
            sof_in  <= 1'b0;
            eof_in  <= 1'b0;
            trig_in <= 1'b0;
        end
    endtask

    task automatic write_cmd(logic [1:0] addr, logic [31:0] data);
        @(posedge pclk);
        cmd_we   <= 1'b1;
        cmd_addr <= addr;
        cmd_data <= data;
    endtask

    // base top bits carry the color so curves differ per color
    task automatic load_table();
        logic [17:0] w;
        write_cmd(`GAMMA_REG_ADDR_DATA, 32'd1 << `GAMMA_ADDR_SEL);
        for (int a = 0; a < 4096; a++) begin
            w = {take_bits(8), 2'(a >> 8), take_bits(8)};
            model_mem[a] = w;
            write_cmd(`GAMMA_REG_ADDR_DATA, {14'b0, w});
        end
        idle(2);
        $display("table load: 4096 words written");
    endtask

    task automatic run_frame(int c, bit acc);
        int          s;
        logic [1:0]  col;
        logic [15:0] px;
        logic [1:0]  bayer;
        bayer = 2'(c_ctrl[c]);
        @(posedge pclk);
        sof_in <= 1'b1;
        idle(2);
        for (int l = 0; l < c_lines[c]; l++) begin
            for (int p = 0; p < c_pix[c]; p++) begin
                s   = subchn_ref(l, c_h[c][0], c_h[c][1], c_h[c][2]);
                col = {bayer[1] ^ (acc & l[0]), bayer[0] ^ p[0]};
                px  = take_bits(16);
                @(posedge pclk);
                hact_in <= 1'b1;
                pxd_in  <= px;
                exp_pix <= interp_ref(model_mem[{2'(s), col, px[15:8]}], px[7:0]);
            end
            idle(3);   // line gap
        end
        @(posedge pclk);
        eof_in <= 1'b1;
        idle(4);
    endtask

    task automatic read_cases(output bit found);
        int    fd;
        int    n;
        int    v [9];
        string line;
        int    total;
        fd = $fopen("verification/sens_gamma_cases.txt", "r");
        total = 4100;
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < max_cases) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %d %d %d %d %d %d %d %d",
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n == 9) begin
                        c_ctrl[num_cases]   = v[0];
                        c_trig[num_cases]   = v[1];
                        c_h[num_cases]      = '{v[2], v[3], v[4]};
                        c_frames[num_cases] = v[5];
                        c_lines[num_cases]  = v[6];
                        c_pix[num_cases]    = v[7];
                        c_sof[num_cases]    = v[8];
                        total += 20 + v[5] * (v[6] * (v[7] + 3) + 8);
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = total * 2 + 200;
        found = (num_cases > 0);
    endtask

    task automatic run_case(int c);
        int errs_before;
        errs_before = err_cnt;
        write_cmd(`GAMMA_REG_CTRL, 32'(c_ctrl[c]));
        write_cmd(`GAMMA_REG_HEIGHT01, {16'(c_h[c][1]), 16'(c_h[c][0])});
        write_cmd(`GAMMA_REG_HEIGHT2, 32'(c_h[c][2]));
        idle(1);
        if (c_trig[c] != 0) begin
            @(posedge pclk);
            trig_in <= 1'b1;
        end
        idle(3);
        sof_cnt = 0;
        for (int f = 0; f < c_frames[c]; f++) begin
            run_frame(c, f < c_sof[c]);
        end
        idle(8);   // drain the pipe
        if (sof_cnt != c_sof[c]) begin
            report_value("sof_out count", c_sof[c], sof_cnt);
        end
        if (err_cnt == errs_before) begin
            $display("case %0d ctrl=%0h: passed", c, c_ctrl[c]);
        end else begin
            $display("case %0d ctrl=%0h: %0d errors", c, c_ctrl[c], err_cnt - errs_before);
            fail_cases++;
        end
    endtask

    // outputs sampled mid-cycle, compared with inputs five cycles back
    always @(negedge pclk) begin
        int idx;
        hist_hact[mon_cyc % hist_len] = hact_in;
        hist_eof[mon_cyc % hist_len]  = eof_in;
        hist_pix[mon_cyc % hist_len]  = exp_pix;
        if (!mrst && mon_cyc >= `GAMMA_LATENCY) begin
            idx = (mon_cyc - `GAMMA_LATENCY) % hist_len;
            if (hact_out !== hist_hact[idx]) report_value("hact_out", hist_hact[idx], hact_out);
            if (eof_out !== hist_eof[idx]) report_value("eof_out", hist_eof[idx], eof_out);
            if (hist_hact[idx] && pxd_out !== hist_pix[idx]) begin
                report_value("pxd_out", hist_pix[idx], pxd_out);
            end
        end
        if (sof_out === 1'b1) sof_cnt++;
        mon_cyc++;
    end

    always @(posedge pclk) begin
        cyc_cnt++;
        if (cyc_cnt > limit) begin
            $display("timeout after %0d cycles, run did not finish", cyc_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        read_cases(ok);
        if (!ok) begin
            $display("case file missing or holds no valid record");
            $display("Simulation failed");
            $finish;
        end else begin
            repeat (2) @(posedge pclk);
            mrst <= 1'b0;
            idle(2);
            load_table();
            for (int c = 0; c < num_cases; c++) begin
                run_case(c);
            end
            if (u_dut.u_chk.fail_cnt != 0) begin
                $display("%0d assertion failures in the bound checker",
                         u_dut.u_chk.fail_cnt);
                err_cnt += u_dut.u_chk.fail_cnt;
            end
            $display("summary: %0d cases, %0d failed, %0d errors", num_cases, fail_cases,
                     err_cnt);
            if (err_cnt == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

// ==== verification/sens_gamma_chk.sv ====
// gamma converter checker, concurrent assertions on alignment, sof, subchannel and reset
`include "gamma_config.svh"

module sens_gamma_chk (
    input  logic                 pclk,
    input  logic                 mrst,
    input  logic                 hact_in,
    input  logic                 hact_out,
    input  logic                 sof_out,
    input  logic                 eof_out,
    input  gamma_pkg::pix_out_t  pxd_out,
    input  gamma_pkg::subchn_t   subchn
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] warm;           // cycles since reset, saturating
    int         fail_cnt = 0;   // assertion failures so far

    always_ff @(posedge pclk) begin
        if (mrst) begin
            warm <= '0;
        end else if (warm != 3'd7) begin
            warm <= warm + 1'b1;
        end
    end

    // line valid travels through the whole pipe unchanged
    hact_delay: assert property (@(posedge pclk) disable iff (mrst || warm < `GAMMA_LATENCY)
        hact_out == $past(hact_in, `GAMMA_LATENCY))
        else begin
            $error("hact_out not aligned with hact_in");
            fail_cnt++;
        end

    sof_single: assert property (@(posedge pclk) disable iff (mrst)
        !(sof_out && $past(sof_out)))
        else begin
            $error("sof_out high for two cycles");
            fail_cnt++;
        end

    subchn_range: assert property (@(posedge pclk) disable iff (mrst)
        subchn < `GAMMA_NUM_CHN)
        else begin
            $error("subchannel out of range");
            fail_cnt++;
        end

    // pipe flushed by reset
    reset_quiet: assert property (@(posedge pclk)
        $fell(mrst) |-> (!hact_out && !sof_out && !eof_out && pxd_out == '0))
        else begin
            $error("outputs active right after reset");
            fail_cnt++;
        end

endmodule

// ==== verilog/sens_gamma.sv ====
// sensor gamma converter top, 16 bit pixels to 8 bit through per-color curves
module sens_gamma (
    input  logic                 pclk,
    input  logic                 mrst,
    input  logic                 cmd_we,
    input  logic [1:0]           cmd_addr,
    input  logic [31:0]          cmd_data,
    input  gamma_pkg::pix_in_t   pxd_in,
    input  logic                 hact_in,
    input  logic                 sof_in,
    input  logic                 eof_in,
    input  logic                 trig_in,
    output gamma_pkg::pix_out_t  pxd_out,
    output logic                 hact_out,
    output logic                 sof_out,
    output logic                 eof_out
);

    gamma_pkg::mode_t        mode;
    logic                    soft_trig;
    gamma_pkg::height_t      height0;
    gamma_pkg::height_t      height1;
    gamma_pkg::height_t      height2;
    gamma_pkg::tbl_wr_t      tbl_wr;      // regs -> memory
    gamma_pkg::sync_t        sync_in;
    gamma_pkg::sync_t        sync_acc;    // sof gated
    gamma_pkg::sync_t        sync_out;
    logic                    frame_run;
    gamma_pkg::subchn_t      subchn;
    gamma_pkg::color_t       color;
    gamma_pkg::table_addr_t  rd_addr;
    gamma_pkg::table_word_t  rd_data;

    assign sync_in  = '{hact: hact_in, sof: sof_in, eof: eof_in};
    assign rd_addr  = {subchn, color, pxd_in[15:8]};  // region, curve, point
    assign hact_out = sync_out.hact;
    assign sof_out  = sync_out.sof;
    assign eof_out  = sync_out.eof;

    gamma_regs u_regs (
        .pclk      (pclk),
        .mrst      (mrst),
        .cmd_we    (cmd_we),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .mode      (mode),
        .soft_trig (soft_trig),
        .height0   (height0),
        .height1   (height1),
        .height2   (height2),
        .tbl_wr    (tbl_wr)
    );

    gamma_frame_ctrl u_frame_ctrl (
        .pclk      (pclk),
        .mrst      (mrst),
        .mode      (mode),
        .soft_trig (soft_trig),
        .trig_in   (trig_in),
        .height0   (height0),
        .height1   (height1),
        .height2   (height2),
        .sync_in   (sync_in),
        .sync_acc  (sync_acc),
        .frame_run (frame_run),
        .subchn    (subchn)
    );

    gamma_color_track u_color_track (
        .pclk      (pclk),
        .mrst      (mrst),
        .mode      (mode),
        .frame_run (frame_run),
        .hact_in   (hact_in),
        .color     (color)
    );

    gamma_table u_table (
        .pclk      (pclk),
        .rd_addr   (rd_addr),
        .rd_en     (hact_in),       // read only for active pixels
        .tbl_wr    (tbl_wr),
        .rd_data   (rd_data)
    );

    gamma_interp u_interp (
        .pclk      (pclk),
        .mrst      (mrst),
        .word      (rd_data),
        .pxd_lo    (pxd_in[7:0]),
        .sync_in   (sync_acc),
        .pxd_out   (pxd_out),
        .sync_out  (sync_out)
    );

endmodule

// ==== verilog/gamma_interp.sv ====
// piecewise-linear interpolation between table points with rounding to 8 bits
`include "gamma_config.svh"

module gamma_interp (
    input  logic                    pclk,
    input  logic                    mrst,
    input  gamma_pkg::table_word_t  word,
    input  logic [7:0]              pxd_lo,
    input  gamma_pkg::sync_t        sync_in,
    output gamma_pkg::pix_out_t     pxd_out,
    output gamma_pkg::sync_t        sync_out
);

    localparam int lo_dly = `GAMMA_LATENCY - 2;  // table read plus one decode stage

    logic [7:0]          lo_d [lo_dly];           // low pixel byte, aligned to diff_r
    gamma_pkg::sync_t    sync_d [`GAMMA_LATENCY];
    logic signed [10:0]  diff_r;                  // decoded slope
    logic [9:0]          base_r;
    logic [9:0]          base_rr;
    logic signed [19:0]  prod;                    // 11b signed x 9b positive
    logic [17:7]         prod_r;                  // bit 7 kept for rounding
    logic [9:0]          interp;

    assign prod     = diff_r * $signed({1'b0, lo_d[lo_dly-1]});
    assign interp   = base_rr + prod_r[17:8] + {9'b0, prod_r[7]}; // wraps mod 1024
    assign sync_out = sync_d[`GAMMA_LATENCY-1];

    // data stages
    always_ff @(posedge pclk) begin
        if (word[17]) begin
            diff_r <= {word[16:10], 4'b0};             // coarse, x16
        end else begin
            diff_r <= {{4{word[16]}}, word[16:10]};    // fine, +/-63
        end
        base_r  <= word[9:0];
        prod_r  <= prod[17:7];
        base_rr <= base_r;
        lo_d[0] <= pxd_lo;
        for (int i = 1; i < lo_dly; i++) begin
            lo_d[i] <= lo_d[i-1];
        end
    end

    // output and sync delay line
    always_ff @(posedge pclk) begin
        if (mrst) begin
            sync_d  <= '{default: '0};
            pxd_out <= '0;
        end else begin
            sync_d[0] <= sync_in;
            for (int i = 1; i < `GAMMA_LATENCY; i++) begin
                sync_d[i] <= sync_d[i-1];
            end
            pxd_out <= interp[9:2];   // drop two guard bits
        end
    end

endmodule

// ==== verilog/gamma_table.sv ====
// curve memory 4096x18, four subchannel regions, command write and pixel read ports
module gamma_table (
    input  logic                    pclk,
    input  gamma_pkg::table_addr_t  rd_addr,
    input  logic                    rd_en,
    input  gamma_pkg::tbl_wr_t      tbl_wr,
    output gamma_pkg::table_word_t  rd_data
);

    localparam int depth = 2 ** $bits(gamma_pkg::table_addr_t);

    gamma_pkg::table_word_t mem [depth];  // {subchn, color, index} addressed
    gamma_pkg::table_word_t rd_q;         // memory read register

    // command side
    always_ff @(posedge pclk) begin
        if (tbl_wr.we) begin
            mem[tbl_wr.addr] <= tbl_wr.data;
        end
    end

    // pixel side, read register then output register
    always_ff @(posedge pclk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];   // only during active pixels
        end
        rd_data <= rd_q;
    end

endmodule

// ==== verilog/gamma_color_track.sv ====
// Bayer color tracking, picks one of four curves for every pixel
module gamma_color_track (
    input  logic               pclk,
    input  logic               mrst,
    input  gamma_pkg::mode_t   mode,
    input  logic               frame_run,
    input  logic               hact_in,
    output gamma_pkg::color_t  color
);

    logic hact_r;
    logic col_ph;   // column phase of the next pixel in the line
    logic row_ph;   // row phase of the current line

    // first pixel of a line always starts at bayer[0]
    assign color = {row_ph, hact_r ? col_ph : mode.bayer[0]};

    always_ff @(posedge pclk) begin
        if (mrst) begin
            hact_r <= 1'b0;
            col_ph <= 1'b0;
            row_ph <= 1'b0;
        end else begin
            hact_r <= hact_in;
            if (hact_in) begin
                col_ph <= ~color[0];           // alternate every active pixel
            end
            if (!frame_run) begin
                row_ph <= mode.bayer[1];       // reloaded until accepted start takes effect
            end else if (hact_r && !hact_in) begin
                row_ph <= ~row_ph;             // next line
            end
        end
    end

endmodule

// ==== verilog/gamma_frame_ctrl.sv ====
// frame gating by enable and trigger, and subchannel selection by line count
`include "gamma_config.svh"

module gamma_frame_ctrl (
    input  logic                  pclk,
    input  logic                  mrst,
    input  gamma_pkg::mode_t      mode,
    input  logic                  soft_trig,
    input  logic                  trig_in,
    input  gamma_pkg::height_t    height0,
    input  gamma_pkg::height_t    height1,
    input  gamma_pkg::height_t    height2,
    input  gamma_pkg::sync_t      sync_in,
    output gamma_pkg::sync_t      sync_acc,
    output logic                  frame_run,
    output gamma_pkg::subchn_t    subchn
);

    localparam gamma_pkg::subchn_t last_chn = `GAMMA_NUM_CHN - 1;

    logic                     pend_trig;  // trigger waiting for a start of frame
    logic                     sof_acc;    // start of frame let through
    logic                     hact_r;
    logic                     line_end;   // first cycle after a line
    gamma_pkg::height_t       line_cnt;   // lines left in this subchannel
    gamma_pkg::frame_state_t  state;

    assign sof_acc   = sync_in.sof && mode.en && (pend_trig || mode.repet);
    assign line_end  = hact_r && !sync_in.hact;
    assign frame_run = (state == gamma_pkg::FRAME_RUN);

    // hact and eof pass untouched, sof only when accepted
    assign sync_acc = '{hact: sync_in.hact, sof: sof_acc, eof: sync_in.eof};

    always_ff @(posedge pclk) begin
        if (mrst) begin
            pend_trig <= 1'b0;
            hact_r    <= 1'b0;
            state     <= gamma_pkg::FRAME_IDLE;
        end else begin
            pend_trig <= trig_in || soft_trig || (pend_trig && !sync_in.sof);
            hact_r    <= sync_in.hact;
            case (state)
                gamma_pkg::FRAME_IDLE: begin
                    if (sof_acc) begin
                        state <= gamma_pkg::FRAME_RUN;
                    end
                end
                gamma_pkg::FRAME_RUN: begin
                    if (sync_in.eof && !sof_acc) begin
                        state <= gamma_pkg::FRAME_IDLE; // frame done
                    end
                end
                default: state <= gamma_pkg::FRAME_IDLE;
            endcase
        end
    end

    // subchannel switch when the line count of the current one runs out
    always_ff @(posedge pclk) begin
        if (mrst) begin
            subchn   <= '0;
            line_cnt <= '0;
        end else if (sync_in.sof) begin
            subchn   <= '0;
            line_cnt <= height0;
        end else if (line_end) begin
            if (line_cnt != '0) begin
                line_cnt <= line_cnt - 1'b1;
            end else if (subchn < last_chn) begin
                subchn   <= subchn + 1'b1;
                line_cnt <= (subchn == 2'd0) ? height1 : height2; // subchn 3 reuses height2
            end
        end
    end

endmodule

// ==== verilog/gamma_regs.sv ====
// gamma command registers: control word, subchannel heights and auto-increment table writes
`include "gamma_config.svh"

module gamma_regs (
    input  logic                pclk,
    input  logic                mrst,
    input  logic                cmd_we,
    input  logic [1:0]          cmd_addr,
    input  logic [31:0]         cmd_data,
    output gamma_pkg::mode_t    mode,
    output logic                soft_trig,
    output gamma_pkg::height_t  height0,
    output gamma_pkg::height_t  height1,
    output gamma_pkg::height_t  height2,
    output gamma_pkg::tbl_wr_t  tbl_wr
);

    logic                   set_ctrl;   // decoded strobes
    logic                   set_taddr;
    logic                   set_tdata;
    logic                   set_h01;
    logic                   set_h2;
    gamma_pkg::table_addr_t taddr;      // next table location
    logic                   wr_we;
    gamma_pkg::table_addr_t wr_addr;
    gamma_pkg::table_word_t wr_data;

    assign set_ctrl  = cmd_we && (cmd_addr == `GAMMA_REG_CTRL);
    assign set_taddr = cmd_we && (cmd_addr == `GAMMA_REG_ADDR_DATA) && cmd_data[`GAMMA_ADDR_SEL];
    assign set_tdata = cmd_we && (cmd_addr == `GAMMA_REG_ADDR_DATA) && !cmd_data[`GAMMA_ADDR_SEL];
    assign set_h01   = cmd_we && (cmd_addr == `GAMMA_REG_HEIGHT01);
    assign set_h2    = cmd_we && (cmd_addr == `GAMMA_REG_HEIGHT2);

    assign tbl_wr = '{we: wr_we, addr: wr_addr, data: wr_data};

    always_ff @(posedge pclk) begin
        if (mrst) begin
            mode      <= '0;
            soft_trig <= 1'b0;
            height0   <= '0;
            height1   <= '0;
            height2   <= '0;
            taddr     <= '0;
            wr_we     <= 1'b0;
        end else begin
            soft_trig <= set_ctrl && cmd_data[`GAMMA_MODE_TRIG]; // single pulse
            wr_we     <= set_tdata;                              // memory writes next cycle
            if (set_ctrl) begin
                mode.bayer <= cmd_data[`GAMMA_MODE_BAYER +: 2];
                mode.en    <= cmd_data[`GAMMA_MODE_EN];
                mode.repet <= cmd_data[`GAMMA_MODE_REPET];
            end
            if (set_h01) begin
                height0 <= cmd_data[15:0];
                height1 <= cmd_data[31:16];
            end
            if (set_h2) begin
                height2 <= cmd_data[15:0];
            end
            if (set_taddr) begin
                taddr <= cmd_data[11:0];  // {subchn, color, index}
            end else if (set_tdata) begin
                taddr <= taddr + 1'b1;    // auto-increment after each word
            end
        end
    end

    // write payload, qualified by wr_we
    always_ff @(posedge pclk) begin
        if (set_tdata) begin
            wr_addr <= taddr;
            wr_data <= cmd_data[17:0];
        end
    end

endmodule

// ==== verilog/gamma_pkg.sv ====
// shared types of the 16 to 8 bit gamma converter
package gamma_pkg;

    typedef logic [15:0] pix_in_t;      // raw sensor pixel
    typedef logic [7:0]  pix_out_t;     // converted pixel
    typedef logic [17:0] table_word_t;  // {coded diff[7:0], base[9:0]}
    typedef logic [11:0] table_addr_t;  // {subchn, color, index}
    typedef logic [15:0] height_t;      // lines minus one
    typedef logic [1:0]  subchn_t;
    typedef logic [1:0]  color_t;       // [1] row phase, [0] column phase

    // same bit order as the control word [3:0]
    typedef struct packed {
        logic       repet;  // accept every frame
        logic       en;     // converter enabled
        logic [1:0] bayer;  // {row, column} phase at frame start
    } mode_t;

    typedef struct packed {
        logic hact;
        logic sof;
        logic eof;
    } sync_t;

    // table write from the register block, 31 bits
    typedef struct packed {
        logic        we;
        table_addr_t addr;
        table_word_t data;
    } tbl_wr_t;

    typedef enum logic {
        FRAME_IDLE,
        FRAME_RUN
    } frame_state_t;

endpackage

// ==== verilog/gamma_config.svh ====
// gamma converter configuration: register map, control bits, subchannels and latency
`ifndef GAMMA_CONFIG_SVH
`define GAMMA_CONFIG_SVH

// subchannels multiplexed on one sensor port (1..4)
`define GAMMA_NUM_CHN         3

// register numbers on the command port
`define GAMMA_REG_CTRL        2'd0  // mode bits and soft trigger
`define GAMMA_REG_ADDR_DATA   2'd1  // table address or table data
`define GAMMA_REG_HEIGHT01    2'd2  // [15:0] height0-1, [31:16] height1-1
`define GAMMA_REG_HEIGHT2     2'd3  // [15:0] height2-1

// bit positions inside the control word
`define GAMMA_MODE_BAYER      0     // two bits wide
`define GAMMA_MODE_EN         2
`define GAMMA_MODE_REPET      3
`define GAMMA_MODE_TRIG       4     // one-shot, not stored

// set in ADDR_DATA -> address write, clear -> data write
`define GAMMA_ADDR_SEL        20

// pixel in to pixel out, in pclk cycles
`define GAMMA_LATENCY         5

`endif
